//--- src/axi_burst_pkg.sv
/*
 * shared definitions for the AXI burst address sequencer
 * bus widths, vector types for addresses, strobes and AXI fields,
 * and the burst-type codes
 */

package axi_burst_pkg;

  // byte address width
  localparam int ADDR_W = 32;

  // byte lanes on the 64-bit data bus
  localparam int DATA_BYTES = 8;

  // log2 of the lane count that selects the lane from an address
  localparam int LANE_W = 3;

  // byte address of a transfer
  typedef logic [ADDR_W-1:0] addr_t;

  // byte-lane strobes, bit i is lane i
  typedef logic [DATA_BYTES-1:0] mask_t;

  // AXI length field, beats minus one
  typedef logic [7:0] len_t;

  // AXI size field, log2 of bytes per beat
  typedef logic [2:0] size_t;

  // AXI burst type field
  typedef logic [1:0] burst_t;

  // beat count up to 256 or bytes per beat up to 128
  typedef logic [8:0] beats_t;

  // burst-type codes
  // the reserved code 3 is not named and behaves like FIXED
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR = 2'd1;
  localparam burst_t BURST_WRAP = 2'd2;

endpackage

//--- src/burst_cmd_decode.sv
/*
 * command decoder of the burst sequencer
 * holds the accepted AXI address command and derives the
 * burst geometry: bytes per beat, burst kind and wrap window
 */

`timescale 1ns/1ps

module burst_cmd_decode
  import axi_burst_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   capture_i,
  input  addr_t  cmd_addr_i,
  input  burst_t cmd_burst_i,
  input  len_t   cmd_len_i,
  input  size_t  cmd_size_i,
  output len_t   len_o,
  output size_t  size_o,
  output logic   is_incr_o,
  output logic   is_wrap_o,
  output beats_t beat_bytes_o,
  output addr_t  wrap_lo_o,
  output addr_t  wrap_hi_o
);

  // command registers
  addr_t  addr_r;
  burst_t burst_r;
  len_t   len_r;
  size_t  size_r;

  // log2 of the beat count for the WRAP lengths
  logic [2:0] lg_beats;
  // lg_beats plus size gives the wrap window shift
  logic [3:0] win_shift;
  // window size in bytes is beats times bytes per beat
  addr_t      win_bytes;

  // start address of the held command
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      addr_r <= cmd_addr_i;
    end
  end

  // burst kind, length and size
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      burst_r <= BURST_FIXED;
      len_r   <= '0;
      size_r  <= '0;
    end else if (capture_i) begin
      burst_r <= cmd_burst_i;
      len_r   <= cmd_len_i;
      size_r  <= cmd_size_i;
    end
  end

  // WRAP only allows 2, 4, 8 or 16 beats
  // log2 lookup for those four lengths
  always_comb begin
    case (len_r)
      8'd1: begin
        lg_beats = 3'd1;
      end
      8'd3: begin
        lg_beats = 3'd2;
      end
      8'd7: begin
        lg_beats = 3'd3;
      end
      8'd15: begin
        lg_beats = 3'd4;
      end
      default: begin
        lg_beats = 3'd0;
      end
    endcase
  end

  assign win_shift = {1'b0, lg_beats} + {1'b0, size_r};
  assign win_bytes = (addr_t'(len_r) + addr_t'(1)) << size_r;

  // lower bound rounds the start down to the window size
  assign wrap_lo_o = (addr_r >> win_shift) << win_shift;
  // upper bound is the first byte past the window
  assign wrap_hi_o = wrap_lo_o + win_bytes;

  // 2^size bytes per beat up to 128
  assign beat_bytes_o = beats_t'(1) << size_r;

  // reserved type falls through as FIXED
  assign is_incr_o = (burst_r == BURST_INCR);
  assign is_wrap_o = (burst_r == BURST_WRAP);

  assign len_o  = len_r;
  assign size_o = size_r;

endmodule

//--- src/burst_addr_pump.sv
/*
 * address pump of the burst sequencer
 * ready/send state machine, beat counter and per-beat address
 * register, with the command ready, beat valid and first/last flags
 */

`timescale 1ns/1ps

module burst_addr_pump
  import axi_burst_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   cmd_v_i,
  input  addr_t  cmd_addr_i,
  output logic   cmd_ready_o,
  output logic   capture_o,
  input  logic   beat_send_i,
  output logic   beat_v_o,
  input  len_t   len_i,
  input  logic   is_incr_i,
  input  logic   is_wrap_i,
  input  beats_t beat_bytes_i,
  input  addr_t  wrap_lo_i,
  input  addr_t  wrap_hi_i,
  output addr_t  addr_o,
  output logic   first_o,
  output logic   last_o
);

  typedef enum logic {
    e_ready,
    e_send
  } state_e;

  state_e state_r;
  state_e state_n;

  // beats already handed over in this burst
  len_t  count_r;
  // address of the current beat
  addr_t addr_r;
  addr_t addr_n;

  // beat bytes widened to the address
  addr_t step;
  // current address rounded down to the beat size
  addr_t aligned_addr;
  // aligned address plus one beat
  addr_t incr_addr;

  logic send;
  logic send_last;

  // command accepted on this edge
  assign capture_o = cmd_v_i & cmd_ready_o;
  assign send      = beat_v_o & beat_send_i;
  assign send_last = send & last_o;

  assign cmd_ready_o = (state_r == e_ready);
  assign beat_v_o    = (state_r == e_send);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_ready: begin
        if (capture_o) begin
          state_n = e_send;
        end
      end
      e_send: begin
        // back to idle once the final beat leaves
        if (send_last) begin
          state_n = e_ready;
        end
      end
      default: begin
        state_n = e_ready;
      end
    endcase
  end

  // counter clears at capture and steps on every consumed beat
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (capture_o) begin
      count_r <= '0;
    end else if (send) begin
      count_r <= count_r + len_t'(1);
    end
  end

  assign first_o = (count_r == '0);
  assign last_o  = (count_r == len_i);

  // beat bytes is a power of two, so clearing its low bits aligns
  assign step         = addr_t'(beat_bytes_i);
  assign aligned_addr = addr_r & ~(step - addr_t'(1));
  assign incr_addr    = aligned_addr + step;

  // FIXED holds, INCR steps, WRAP steps and folds back at the window top
  always_comb begin
    addr_n = addr_r;
    if (is_wrap_i) begin
      addr_n = (incr_addr >= wrap_hi_i) ? wrap_lo_i : incr_addr;
    end else if (is_incr_i) begin
      addr_n = incr_addr;
    end
  end

  // start address at capture, next address at each send
  always_ff @(posedge clk_i) begin
    if (capture_o) begin
      addr_r <= cmd_addr_i;
    end else if (send) begin
      addr_r <= addr_n;
    end
  end

  assign addr_o = addr_r;

endmodule

//--- src/beat_lane_mask.sv
/*
 * byte-lane strobe formatter
 * turns the current beat address and size into the strobe mask
 * of the 64-bit data bus, with zero latency
 */

`timescale 1ns/1ps

module beat_lane_mask
  import axi_burst_pkg::*;
(
  input  addr_t addr_i,
  input  size_t size_i,
  output mask_t mask_o
);

  // bytes in one beat up to 128
  beats_t beat_bytes;
  // lane offset of the address inside the bus word
  logic [LANE_W-1:0] lo_lane;
  // lane offset of the size-aligned address
  logic [LANE_W-1:0] aligned_lane;
  // last byte of the beat relative to the bus word which may pass lane 7
  beats_t hi_sum;
  // last strobed lane after clipping
  logic [LANE_W-1:0] hi_lane;

  assign beat_bytes = beats_t'(1) << size_i;

  // address modulo DATA_BYTES
  assign lo_lane = addr_i[LANE_W-1:0];

  // only the low lane bits matter for the alignment here
  assign aligned_lane = lo_lane & ~(beat_bytes[LANE_W-1:0] - LANE_W'(1));

  // aligned lane plus beat bytes minus one
  assign hi_sum = beats_t'(aligned_lane) + beat_bytes - beats_t'(1);

  // beats wider than the bus stop at the top lane
  always_comb begin
    if (hi_sum >= beats_t'(DATA_BYTES)) begin
      hi_lane = LANE_W'(DATA_BYTES - 1);
    end else begin
      hi_lane = hi_sum[LANE_W-1:0];
    end
  end

  // strobe every lane from lo_lane to hi_lane inclusive
  // an unaligned start trims the low lanes of the first beat
  always_comb begin
    for (int i = 0; i < DATA_BYTES; i++) begin
      mask_o[i] = (LANE_W'(i) >= lo_lane) && (LANE_W'(i) <= hi_lane);
    end
  end

endmodule

//--- src/axi_burst_sequencer.sv
/*
 * AXI burst address sequencer top level
 * connects the command decoder, the address pump and the
 * lane mask block
 */

`timescale 1ns/1ps

module axi_burst_sequencer
  import axi_burst_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  // command side
  input  logic   cmd_v_i,
  input  addr_t  cmd_addr_i,
  input  burst_t cmd_burst_i,
  input  len_t   cmd_len_i,
  input  size_t  cmd_size_i,
  output logic   cmd_ready_o,
  // beat side
  output logic   beat_v_o,
  output addr_t  beat_addr_o,
  output mask_t  beat_mask_o,
  output size_t  beat_size_o,
  output len_t   beat_len_o,
  output logic   beat_first_o,
  output logic   beat_last_o,
  input  logic   beat_send_i
);

  // acceptance pulse from the pump to the decoder
  logic   capture;
  // registered burst geometry
  len_t   len;
  size_t  size;
  logic   is_incr;
  logic   is_wrap;
  beats_t beat_bytes;
  addr_t  wrap_lo;
  addr_t  wrap_hi;

  burst_cmd_decode decode0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .capture_i    (capture),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_burst_i  (cmd_burst_i),
    .cmd_len_i    (cmd_len_i),
    .cmd_size_i   (cmd_size_i),
    .len_o        (len),
    .size_o       (size),
    .is_incr_o    (is_incr),
    .is_wrap_o    (is_wrap),
    .beat_bytes_o (beat_bytes),
    .wrap_lo_o    (wrap_lo),
    .wrap_hi_o    (wrap_hi)
  );

  burst_addr_pump pump0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_ready_o  (cmd_ready_o),
    .capture_o    (capture),
    .beat_send_i  (beat_send_i),
    .beat_v_o     (beat_v_o),
    .len_i        (len),
    .is_incr_i    (is_incr),
    .is_wrap_i    (is_wrap),
    .beat_bytes_i (beat_bytes),
    .wrap_lo_i    (wrap_lo),
    .wrap_hi_i    (wrap_hi),
    .addr_o       (beat_addr_o),
    .first_o      (beat_first_o),
    .last_o       (beat_last_o)
  );

  // strobes follow the current beat address with no delay
  beat_lane_mask mask0 (
    .addr_i (beat_addr_o),
    .size_i (size),
    .mask_o (beat_mask_o)
  );

  // size and length echo the held command
  assign beat_size_o = size;
  assign beat_len_o  = len;

endmodule

//--- sim/tb_clock_gen.sv
/*
 * testbench clock source
 * free-running clock with a 100 ns period
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // half of the 100 ns period
  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk_o = 1'b0;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

//--- sim/axi_burst_chk.sv
/*
 * protocol assertions for the burst sequencer
 * exclusive ready/valid, hold under back-pressure, reset state
 * bound into the top level
 */

`timescale 1ns/1ps

module axi_burst_chk
  import axi_burst_pkg::*;
(
  input logic  clk_i,
  input logic  reset_i,
  input logic  cmd_ready_o,
  input logic  beat_v_o,
  input logic  beat_send_i,
  input addr_t beat_addr_o,
  input mask_t beat_mask_o,
  input size_t beat_size_o,
  input len_t  beat_len_o,
  input logic  beat_first_o,
  input logic  beat_last_o
);

  // command side and beat side never active in the same cycle
  a_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(beat_v_o && cmd_ready_o))
    else $error("beat valid and command ready are high together");

  // a stalled beat keeps every field until it is taken
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (beat_v_o && !beat_send_i) |=> (beat_v_o && $stable(beat_addr_o) &&
      $stable(beat_mask_o) && $stable(beat_size_o) && $stable(beat_len_o) &&
      $stable(beat_first_o) && $stable(beat_last_o)))
    else $error("beat outputs changed while the beat was stalled");

  // idle state right after a reset edge
  a_reset: assert property (@(posedge clk_i) reset_i |=> (cmd_ready_o && !beat_v_o))
    else $error("ready or valid wrong after reset");

endmodule

bind axi_burst_sequencer axi_burst_chk chk0 (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .cmd_ready_o  (cmd_ready_o),
  .beat_v_o     (beat_v_o),
  .beat_send_i  (beat_send_i),
  .beat_addr_o  (beat_addr_o),
  .beat_mask_o  (beat_mask_o),
  .beat_size_o  (beat_size_o),
  .beat_len_o   (beat_len_o),
  .beat_first_o (beat_first_o),
  .beat_last_o  (beat_last_o)
);

//--- sim/axi_burst_tb.sv
/*
 * testbench for the AXI burst address sequencer
 * LFSR-driven commands and beat back-pressure, a reference model
 * of the FIXED/INCR/WRAP address and strobe rules, typed compare
 * tasks and a cycle timeout
 */

`timescale 1ns/1ps

module axi_burst_tb
  import axi_burst_pkg::*;
();

  localparam int NUM_CMDS = 200;
  // 16 beats at half send density plus the command wait and a wide margin
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 100;
  localparam int RESET_CYCLES = 16;
  localparam time DRIVE_DELAY = 10ns;

  logic clk;
  logic reset_i;
  logic cmd_v_i;
  addr_t cmd_addr_i;
  burst_t cmd_burst_i;
  len_t cmd_len_i;
  size_t cmd_size_i;
  logic cmd_ready_o;
  logic beat_v_o;
  addr_t beat_addr_o;
  mask_t beat_mask_o;
  size_t beat_size_o;
  len_t beat_len_o;
  logic beat_first_o;
  logic beat_last_o;
  logic beat_send_i;

  logic [15:0] lfsr_r;
  int cycle_count;

  tb_clock_gen clk_gen0 (.clk_o(clk));

  axi_burst_sequencer dut0 (
    .clk_i        (clk),
    .reset_i      (reset_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_burst_i  (cmd_burst_i),
    .cmd_len_i    (cmd_len_i),
    .cmd_size_i   (cmd_size_i),
    .cmd_ready_o  (cmd_ready_o),
    .beat_v_o     (beat_v_o),
    .beat_addr_o  (beat_addr_o),
    .beat_mask_o  (beat_mask_o),
    .beat_size_o  (beat_size_o),
    .beat_len_o   (beat_len_o),
    .beat_first_o (beat_first_o),
    .beat_last_o  (beat_last_o),
    .beat_send_i  (beat_send_i)
  );

  // maximal-length taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = lfsr_next(lfsr_r);
      v = {v[30:0], lfsr_r[0]};
    end
    return v;
  endfunction

  // model rounding of an address down to the beat size
  function automatic addr_t align_down(input addr_t a, input size_t s);
    return (a >> s) << s;
  endfunction

  // model strobes from the address up to the end of its aligned block
  function automatic mask_t lane_strobes(input addr_t a, input size_t s);
    int lo;
    int hi;
    mask_t m;
    lo = int'(a % addr_t'(DATA_BYTES));
    hi = int'(align_down(a, s) % addr_t'(DATA_BYTES)) + (1 << s) - 1;
    if (hi > DATA_BYTES - 1) begin
      hi = DATA_BYTES - 1;
    end
    m = '0;
    for (int i = 0; i < DATA_BYTES; i++) begin
      if (i >= lo && i <= hi) begin
        m[i] = 1'b1;
      end
    end
    return m;
  endfunction

  // model address of the following beat
  function automatic addr_t next_addr(input addr_t a, input burst_t b, input size_t s,
                                      input addr_t lo, input addr_t hi);
    addr_t n;
    n = align_down(a, s) + (addr_t'(1) << s);
    if (b == BURST_WRAP) begin
      if (n >= hi) begin
        n = lo;
      end
    end else if (b != BURST_INCR) begin
      // FIXED and the reserved code repeat the start
      n = a;
    end
    return n;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_len(input string name, input len_t got, input len_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_size(input string name, input size_t got, input size_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error %s got %h expected %h", name, got, exp));
    end
  endtask

  // one command that waits for acceptance and then walks every beat
  task automatic run_burst();
    addr_t c_addr;
    burst_t c_burst;
    len_t c_len;
    size_t c_size;
    addr_t win;
    addr_t w_lo;
    addr_t w_hi;
    addr_t cur;
    logic accepted;
    int k;
    c_size = size_t'(take_bits(2));
    c_burst = burst_t'(take_bits(2));
    // code 3 is left out of the stimulus
    if (c_burst == 2'd3) begin
      c_burst = BURST_INCR;
    end
    c_addr = addr_t'(take_bits(20));
    if (c_burst == BURST_WRAP) begin
      // 2, 4, 8 or 16 beats from a size-aligned start
      c_len = len_t'((1 << (take_bits(2) + 1)) - 1);
      c_addr = align_down(c_addr, c_size);
    end else begin
      c_len = len_t'(take_bits(4));
    end
    win = (addr_t'(c_len) + addr_t'(1)) << c_size;
    w_lo = c_addr - (c_addr % win);
    w_hi = w_lo + win;
    accepted = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cmd_v_i = take_bits(1) != 0;
      cmd_addr_i = c_addr;
      cmd_burst_i = c_burst;
      cmd_len_i = c_len;
      cmd_size_i = c_size;
      // send while idle has to be ignored
      beat_send_i = take_bits(1) != 0;
      @(negedge clk);
      check_flag("cmd_ready_o", cmd_ready_o, 1'b1);
      check_flag("beat_v_o", beat_v_o, 1'b0);
      accepted = cmd_v_i;
    end
    k = 0;
    cur = c_addr;
    while (k <= int'(c_len)) begin
      @(posedge clk);
      #DRIVE_DELAY;
      // stray commands mid-burst must not be taken
      cmd_v_i = take_bits(1) != 0;
      cmd_addr_i = addr_t'(take_bits(20));
      cmd_burst_i = burst_t'(take_bits(2));
      cmd_len_i = len_t'(take_bits(4));
      cmd_size_i = size_t'(take_bits(2));
      beat_send_i = take_bits(1) != 0;
      @(negedge clk);
      check_flag("beat_v_o", beat_v_o, 1'b1);
      check_flag("cmd_ready_o", cmd_ready_o, 1'b0);
      check_addr("beat_addr_o", beat_addr_o, cur);
      check_mask("beat_mask_o", beat_mask_o, lane_strobes(cur, c_size));
      check_size("beat_size_o", beat_size_o, c_size);
      check_len("beat_len_o", beat_len_o, c_len);
      check_flag("beat_first_o", beat_first_o, k == 0);
      check_flag("beat_last_o", beat_last_o, k == int'(c_len));
      if (beat_send_i) begin
        k++;
        cur = next_addr(cur, c_burst, c_size, w_lo, w_hi);
      end
    end
  endtask

  // hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    lfsr_r = 16'd14631;
    cycle_count = 0;
    reset_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_addr_i = '0;
    cmd_burst_i = BURST_FIXED;
    cmd_len_i = '0;
    cmd_size_i = '0;
    beat_send_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    for (int n = 0; n < NUM_CMDS; n++) begin
      run_burst();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

//--- sources.f
src/axi_burst_pkg.sv
src/burst_cmd_decode.sv
src/burst_addr_pump.sv
src/beat_lane_mask.sv
src/axi_burst_sequencer.sv
sim/tb_clock_gen.sv
sim/axi_burst_chk.sv
sim/axi_burst_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= axi_burst_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := tests failed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
